/* source/axim_params.svh */
`ifndef AXIM_PARAMS_SVH
`define AXIM_PARAMS_SVH

// Byte address width on the AXI side
`define AXIM_ADDR_W 32

// One beat is one data word
`define AXIM_DATA_W 32

// Strobe width follows the data width
`define AXIM_STRB_W (`AXIM_DATA_W / 8)

// Transfer size counter, in bytes
`define AXIM_XFER_W 32

// Longest burst the master will issue, in beats
`define AXIM_MAX_BURST 16

`endif

/* source/axim_pkg.sv */
`include "axim_params.svh"

package axim_pkg;

   typedef logic [`AXIM_ADDR_W-1:0] axi_addr_t;
   typedef logic [`AXIM_DATA_W-1:0] axi_data_t;
   typedef logic [`AXIM_STRB_W-1:0] axi_strb_t;
   // AXI encoding, beats minus one
   typedef logic [7:0]              axi_len_t;
   typedef logic [`AXIM_XFER_W-1:0] xfer_size_t;

   // Shared by AW and AR
   typedef struct packed {
      axi_addr_t addr;
      axi_len_t  len;
   } axi_ax_t;

   typedef struct packed {
      axi_data_t data;
      axi_strb_t strb;
      logic      last;
   } axi_w_t;

   typedef struct packed {
      axi_data_t data;
      logic      last;
   } axi_r_t;

   typedef enum logic [2:0] {
      IDLE,
      RD_ADDR,
      RD_DATA,
      WR_ADDR,
      WR_DATA,
      WR_RESP
   } ctrl_state_e;

endpackage

/* source/axim_ctrl_fsm.sv */
`timescale 1ns/1ps

module axim_ctrl_fsm (
   input  logic clk,
   input  logic arst_n_i,
   input  logic ctrl_rstart_i,
   input  logic ctrl_wstart_i,
   input  logic ctrl_wstrb_msk_en_i,
   input  logic last_burst_i,
   input  logic rd_burst_end_i,
   input  logic wr_burst_end_i,
   input  logic arready_i,
   input  logic awready_i,
   input  logic bvalid_i,
   output logic arvalid_o,
   output logic awvalid_o,
   output logic bready_o,
   output logic addr_load_o,
   output logic addr_step_o,
   output logic load_wr_o,
   output logic rd_en_o,
   output logic wr_en_o,
   output logic msk_en_o,
   output logic ctrl_rdone_o,
   output logic ctrl_wdone_o
);

   axim_pkg::ctrl_state_e state_q;
   axim_pkg::ctrl_state_e state_d;

   logic rd_pend_q;
   logic wr_pend_q;
   logic msk_pend_q;
   logic msk_q;
   logic rdone_q;
   logic wdone_q;

   logic rd_req;
   logic wr_req;
   logic take_rd;
   logic take_wr;
   logic rd_finish;
   logic wr_finish;

   // A start in this very cycle counts as pending already
   assign rd_req  = rd_pend_q | ctrl_rstart_i;
   assign wr_req  = wr_pend_q | ctrl_wstart_i;

   // Read wins when both are waiting
   assign take_rd = (state_q == axim_pkg::IDLE) & rd_req;
   assign take_wr = (state_q == axim_pkg::IDLE) & ~rd_req & wr_req;

   assign rd_finish = (state_q == axim_pkg::RD_DATA) & rd_burst_end_i & last_burst_i;
   assign wr_finish = (state_q == axim_pkg::WR_RESP) & bvalid_i & last_burst_i;

   assign addr_load_o = take_rd | take_wr;
   assign load_wr_o   = take_wr;

   // Next burst only once the current one is fully closed
   assign addr_step_o = ((state_q == axim_pkg::RD_DATA) & rd_burst_end_i & ~last_burst_i) |
                        ((state_q == axim_pkg::WR_RESP) & bvalid_i & ~last_burst_i);

   assign arvalid_o = (state_q == axim_pkg::RD_ADDR);
   assign awvalid_o = (state_q == axim_pkg::WR_ADDR);
   assign bready_o  = (state_q == axim_pkg::WR_RESP);
   assign rd_en_o   = (state_q == axim_pkg::RD_DATA);
   assign wr_en_o   = (state_q == axim_pkg::WR_DATA);
   assign msk_en_o  = msk_q;

   assign ctrl_rdone_o = rdone_q;
   assign ctrl_wdone_o = wdone_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         axim_pkg::IDLE: begin
            if (take_rd) begin
               state_d = axim_pkg::RD_ADDR;
            end else if (take_wr) begin
               state_d = axim_pkg::WR_ADDR;
            end
         end
         axim_pkg::RD_ADDR: begin
            if (arready_i) begin
               state_d = axim_pkg::RD_DATA;
            end
         end
         axim_pkg::RD_DATA: begin
            if (rd_burst_end_i) begin
               state_d = last_burst_i ? axim_pkg::IDLE : axim_pkg::RD_ADDR;
            end
         end
         axim_pkg::WR_ADDR: begin
            if (awready_i) begin
               state_d = axim_pkg::WR_DATA;
            end
         end
         axim_pkg::WR_DATA: begin
            if (wr_burst_end_i) begin
               state_d = axim_pkg::WR_RESP;
            end
         end
         axim_pkg::WR_RESP: begin
            if (bvalid_i) begin
               state_d = last_burst_i ? axim_pkg::IDLE : axim_pkg::WR_ADDR;
            end
         end
         default: begin
            state_d = axim_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= axim_pkg::IDLE;
         rd_pend_q  <= 1'b0;
         wr_pend_q  <= 1'b0;
         msk_pend_q <= 1'b0;
         msk_q      <= 1'b0;
         rdone_q    <= 1'b0;
         wdone_q    <= 1'b0;
      end else begin
         state_q   <= state_d;
         rd_pend_q <= rd_req & ~take_rd;
         wr_pend_q <= wr_req & ~take_wr;
         // Mask enable belongs to the request, so keep it with the pending write
         if (ctrl_wstart_i) begin
            msk_pend_q <= ctrl_wstrb_msk_en_i;
         end
         if (take_wr) begin
            msk_q <= ctrl_wstart_i ? ctrl_wstrb_msk_en_i : msk_pend_q;
         end
         rdone_q <= rd_finish;
         wdone_q <= wr_finish;
      end
   end

endmodule

/* source/axim_burst_addr.sv */
`timescale 1ns/1ps
`include "axim_params.svh"

module axim_burst_addr (
   input  logic                 clk,
   input  logic                 arst_n_i,
   input  logic                 addr_load_i,
   input  logic                 addr_step_i,
   input  logic                 load_wr_i,
   input  axim_pkg::axi_addr_t  ctrl_baseaddr_i,
   input  axim_pkg::axi_addr_t  ctrl_raddr_offset_i,
   input  axim_pkg::axi_addr_t  ctrl_waddr_offset_i,
   input  axim_pkg::xfer_size_t ctrl_rxfer_size_i,
   input  axim_pkg::xfer_size_t ctrl_wxfer_size_i,
   output axim_pkg::axi_ax_t    cur_ax_o,
   output logic                 last_burst_o
);

   localparam int unsigned BEAT_BYTES  = `AXIM_DATA_W / 8;
   localparam int unsigned BEAT_SHIFT  = $clog2(BEAT_BYTES);
   localparam int unsigned BURST_BYTES = `AXIM_MAX_BURST * BEAT_BYTES;

   axim_pkg::axi_addr_t  addr_q;
   axim_pkg::xfer_size_t remain_q;
   axim_pkg::xfer_size_t burst_bytes;

   // Whatever is left fits in one burst
   assign last_burst_o = (remain_q <= axim_pkg::xfer_size_t'(BURST_BYTES));
   assign burst_bytes  = last_burst_o ? remain_q : axim_pkg::xfer_size_t'(BURST_BYTES);

   assign cur_ax_o = '{
      addr: addr_q,
      len:  axim_pkg::axi_len_t'((burst_bytes >> BEAT_SHIFT) - 1'b1)
   };

   always_ff @(posedge clk) begin
      if (addr_load_i) begin
         addr_q <= ctrl_baseaddr_i + (load_wr_i ? ctrl_waddr_offset_i : ctrl_raddr_offset_i);
      end else if (addr_step_i) begin
         addr_q <= addr_q + axim_pkg::axi_addr_t'(BURST_BYTES);
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         remain_q <= '0;
      end else if (addr_load_i) begin
         remain_q <= load_wr_i ? ctrl_wxfer_size_i : ctrl_rxfer_size_i;
      end else if (addr_step_i) begin
         remain_q <= remain_q - burst_bytes;
      end
   end

endmodule

/* source/axim_rd_path.sv */
`timescale 1ns/1ps

module axim_rd_path (
   input  logic                clk,
   input  logic                arst_n_i,
   input  logic                rd_en_i,
   input  logic                last_burst_i,
   input  axim_pkg::axi_r_t    r_i,
   input  logic                rvalid_i,
   output logic                rready_o,
   output axim_pkg::axi_data_t rd_tdata_o,
   output logic                rd_tvalid_o,
   output logic                rd_tlast_o,
   input  logic                rd_tready_i,
   output logic                rd_burst_end_o
);

   logic r_fire;

   // Consumer back-pressure goes straight onto R
   assign rready_o    = rd_en_i & rd_tready_i;
   assign rd_tvalid_o = rd_en_i & rvalid_i;
   assign rd_tdata_o  = r_i.data;

   // Only the final burst's rlast ends the stream
   assign rd_tlast_o  = rd_tvalid_o & r_i.last & last_burst_i;

   assign r_fire         = rvalid_i & rready_o;
   assign rd_burst_end_o = r_fire & r_i.last;

endmodule

/* source/axim_wr_path.sv */
`timescale 1ns/1ps

module axim_wr_path (
   input  logic                clk,
   input  logic                arst_n_i,
   input  logic                wr_en_i,
   input  logic                msk_en_i,
   input  axim_pkg::axi_len_t  burst_len_i,
   input  axim_pkg::axi_data_t wr_tdata_i,
   input  axim_pkg::axi_strb_t wr_tstrb_msk_i,
   input  logic                wr_tvalid_i,
   output logic                wr_tready_o,
   output axim_pkg::axi_w_t    w_o,
   output logic                wvalid_o,
   input  logic                wready_i,
   output logic                wr_burst_end_o
);

   axim_pkg::axi_len_t beat_cnt_q;
   logic               beat_last;
   logic               w_fire;

   assign beat_last = (beat_cnt_q == burst_len_i);

   assign wvalid_o    = wr_en_i & wr_tvalid_i;
   // W stalls reach the producer unchanged
   assign wr_tready_o = wr_en_i & wready_i;

   // Without mask enable every byte lane is written
   assign w_o = '{
      data: wr_tdata_i,
      strb: msk_en_i ? wr_tstrb_msk_i : '1,
      last: beat_last
   };

   assign w_fire         = wvalid_o & wready_i;
   assign wr_burst_end_o = w_fire & beat_last;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         beat_cnt_q <= '0;
      end else if (w_fire) begin
         if (beat_last) begin
            beat_cnt_q <= '0;
         end else begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
         end
      end
   end

endmodule

/* source/v_mem_subsystem.sv */
`timescale 1ns/1ps

module v_mem_subsystem (
   input  logic                 clk,
   input  logic                 arst_n_i,
   // Core side
   input  axim_pkg::axi_addr_t  ctrl_baseaddr_i,
   input  logic                 ctrl_rstart_i,
   input  axim_pkg::axi_addr_t  ctrl_raddr_offset_i,
   input  axim_pkg::xfer_size_t ctrl_rxfer_size_i,
   output logic                 ctrl_rdone_o,
   output axim_pkg::axi_data_t  rd_tdata_o,
   output logic                 rd_tvalid_o,
   output logic                 rd_tlast_o,
   input  logic                 rd_tready_i,
   input  logic                 ctrl_wstart_i,
   input  axim_pkg::axi_addr_t  ctrl_waddr_offset_i,
   input  axim_pkg::xfer_size_t ctrl_wxfer_size_i,
   input  logic                 ctrl_wstrb_msk_en_i,
   output logic                 ctrl_wdone_o,
   input  axim_pkg::axi_data_t  wr_tdata_i,
   input  axim_pkg::axi_strb_t  wr_tstrb_msk_i,
   input  logic                 wr_tvalid_i,
   output logic                 wr_tready_o,
   // AXI master
   output axim_pkg::axi_ax_t    aw_o,
   output logic                 awvalid_o,
   input  logic                 awready_i,
   output axim_pkg::axi_w_t     w_o,
   output logic                 wvalid_o,
   input  logic                 wready_i,
   input  logic                 bvalid_i,
   output logic                 bready_o,
   output axim_pkg::axi_ax_t    ar_o,
   output logic                 arvalid_o,
   input  logic                 arready_i,
   input  axim_pkg::axi_r_t     r_i,
   input  logic                 rvalid_i,
   output logic                 rready_o
);

   logic              addr_load;
   logic              addr_step;
   logic              load_wr;
   logic              last_burst;
   logic              rd_en;
   logic              wr_en;
   logic              msk_en;
   logic              rd_burst_end;
   logic              wr_burst_end;
   axim_pkg::axi_ax_t cur_ax;

   // Only one burst is ever open, so AW and AR share the generator
   assign aw_o = cur_ax;
   assign ar_o = cur_ax;

   axim_ctrl_fsm ctrl_fsm_i (
      .clk                 (clk),
      .arst_n_i            (arst_n_i),
      .ctrl_rstart_i       (ctrl_rstart_i),
      .ctrl_wstart_i       (ctrl_wstart_i),
      .ctrl_wstrb_msk_en_i (ctrl_wstrb_msk_en_i),
      .last_burst_i        (last_burst),
      .rd_burst_end_i      (rd_burst_end),
      .wr_burst_end_i      (wr_burst_end),
      .arready_i           (arready_i),
      .awready_i           (awready_i),
      .bvalid_i            (bvalid_i),
      .arvalid_o           (arvalid_o),
      .awvalid_o           (awvalid_o),
      .bready_o            (bready_o),
      .addr_load_o         (addr_load),
      .addr_step_o         (addr_step),
      .load_wr_o           (load_wr),
      .rd_en_o             (rd_en),
      .wr_en_o             (wr_en),
      .msk_en_o            (msk_en),
      .ctrl_rdone_o        (ctrl_rdone_o),
      .ctrl_wdone_o        (ctrl_wdone_o)
   );

   axim_burst_addr burst_addr_i (
      .clk                 (clk),
      .arst_n_i            (arst_n_i),
      .addr_load_i         (addr_load),
      .addr_step_i         (addr_step),
      .load_wr_i           (load_wr),
      .ctrl_baseaddr_i     (ctrl_baseaddr_i),
      .ctrl_raddr_offset_i (ctrl_raddr_offset_i),
      .ctrl_waddr_offset_i (ctrl_waddr_offset_i),
      .ctrl_rxfer_size_i   (ctrl_rxfer_size_i),
      .ctrl_wxfer_size_i   (ctrl_wxfer_size_i),
      .cur_ax_o            (cur_ax),
      .last_burst_o        (last_burst)
   );

   axim_rd_path rd_path_i (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .rd_en_i        (rd_en),
      .last_burst_i   (last_burst),
      .r_i            (r_i),
      .rvalid_i       (rvalid_i),
      .rready_o       (rready_o),
      .rd_tdata_o     (rd_tdata_o),
      .rd_tvalid_o    (rd_tvalid_o),
      .rd_tlast_o     (rd_tlast_o),
      .rd_tready_i    (rd_tready_i),
      .rd_burst_end_o (rd_burst_end)
   );

   axim_wr_path wr_path_i (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .wr_en_i        (wr_en),
      .msk_en_i       (msk_en),
      .burst_len_i    (cur_ax.len),
      .wr_tdata_i     (wr_tdata_i),
      .wr_tstrb_msk_i (wr_tstrb_msk_i),
      .wr_tvalid_i    (wr_tvalid_i),
      .wr_tready_o    (wr_tready_o),
      .w_o            (w_o),
      .wvalid_o       (wvalid_o),
      .wready_i       (wready_i),
      .wr_burst_end_o (wr_burst_end)
   );

endmodule

/* verification/axim_mem_model.sv */
`timescale 1ns/1ps
`include "axim_params.svh"

module axim_mem_model #(
   parameter int unsigned MEM_WORDS = 4096
) (
   input  logic              clk,
   input  logic              arst_n_i,
   input  axim_pkg::axi_ax_t aw_i,
   input  logic              awvalid_i,
   output logic              awready_o,
   input  axim_pkg::axi_w_t  w_i,
   input  logic              wvalid_i,
   output logic              wready_o,
   output logic              bvalid_o,
   input  logic              bready_i,
   input  axim_pkg::axi_ax_t ar_i,
   input  logic              arvalid_i,
   output logic              arready_o,
   output axim_pkg::axi_r_t  r_o,
   output logic              rvalid_o,
   input  logic              rready_i
);

   localparam int unsigned         BEAT_BYTES = `AXIM_DATA_W / 8;
   localparam axim_pkg::axi_data_t FILL_KEY   = 32'h3c5a_9e17;

   axim_pkg::axi_data_t mem [0:MEM_WORDS-1];

   // Every accepted address phase, in order
   axim_pkg::axi_ax_t   ar_log_q [$];
   axim_pkg::axi_ax_t   aw_log_q [$];

   axim_pkg::axi_addr_t rd_addr_q;
   axim_pkg::axi_len_t  rd_len_q;
   axim_pkg::axi_len_t  rd_cnt_q;
   logic                rd_busy_q;
   axim_pkg::axi_addr_t wr_addr_q;
   logic                b_pend_q;

   function automatic int unsigned word_index(input axim_pkg::axi_addr_t addr);
      return (addr / BEAT_BYTES) % MEM_WORDS;
   endfunction

   // Ready or valid is offered three times out of four
   function automatic logic random_bit();
      return ($urandom % 4) != 0;
   endfunction

   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = axim_pkg::axi_data_t'(i * BEAT_BYTES) ^ FILL_KEY;
      end
   end

   assign r_o = '{data: mem[word_index(rd_addr_q)], last: (rd_cnt_q == rd_len_q)};

   // AR and R channels
   always @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         arready_o <= 1'b0;
         rvalid_o  <= 1'b0;
         rd_busy_q <= 1'b0;
         rd_addr_q <= '0;
         rd_len_q  <= '0;
         rd_cnt_q  <= '0;
      end else begin
         arready_o <= random_bit();
         if (arvalid_i && arready_o) begin
            ar_log_q.push_back(ar_i);
            rd_addr_q <= ar_i.addr;
            rd_len_q  <= ar_i.len;
            rd_cnt_q  <= '0;
            rd_busy_q <= 1'b1;
            rvalid_o  <= random_bit();
         end else if (rd_busy_q) begin
            if (rvalid_o && rready_i) begin
               if (rd_cnt_q == rd_len_q) begin
                  rd_busy_q <= 1'b0;
                  rvalid_o  <= 1'b0;
               end else begin
                  rd_addr_q <= rd_addr_q + axim_pkg::axi_addr_t'(BEAT_BYTES);
                  rd_cnt_q  <= rd_cnt_q + 8'd1;
                  rvalid_o  <= random_bit();
               end
            end else if (!rvalid_o) begin
               rvalid_o <= random_bit();
            end
         end
      end
   end

   // AW, W and B channels
   always @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         awready_o <= 1'b0;
         wready_o  <= 1'b0;
         bvalid_o  <= 1'b0;
         b_pend_q  <= 1'b0;
         wr_addr_q <= '0;
      end else begin
         awready_o <= random_bit();
         wready_o  <= random_bit();
         if (awvalid_i && awready_o) begin
            aw_log_q.push_back(aw_i);
            wr_addr_q <= aw_i.addr;
         end
         if (wvalid_i && wready_o) begin
            for (int b = 0; b < BEAT_BYTES; b++) begin
               if (w_i.strb[b]) begin
                  mem[word_index(wr_addr_q)][8*b +: 8] <= w_i.data[8*b +: 8];
               end
            end
            wr_addr_q <= wr_addr_q + axim_pkg::axi_addr_t'(BEAT_BYTES);
            if (w_i.last) begin
               b_pend_q <= 1'b1;
            end
         end
         if (b_pend_q) begin
            if (bvalid_o && bready_i) begin
               bvalid_o <= 1'b0;
               b_pend_q <= 1'b0;
            end else if (!bvalid_o) begin
               bvalid_o <= random_bit();
            end
         end
      end
   end

endmodule

/* verification/tb_v_mem_subsystem.sv */
`timescale 1ns/1ps
`include "axim_params.svh"

module tb_v_mem_subsystem;

   localparam int unsigned         NUM_TESTS   = 10;
   localparam int unsigned         PAT_FIELDS  = 6;
   localparam int unsigned         MEM_WORDS   = 4096;
   localparam int unsigned         BEAT_BYTES  = `AXIM_DATA_W / 8;
   localparam int unsigned         BURST_BYTES = `AXIM_MAX_BURST * BEAT_BYTES;
   localparam axim_pkg::axi_addr_t BASE_ADDR   = 32'h0000_1000;
   localparam axim_pkg::axi_data_t FILL_KEY    = 32'h3c5a_9e17;

   logic                 clk;
   logic                 arst_n_i;
   axim_pkg::axi_addr_t  ctrl_baseaddr_i;
   logic                 ctrl_rstart_i;
   axim_pkg::axi_addr_t  ctrl_raddr_offset_i;
   axim_pkg::xfer_size_t ctrl_rxfer_size_i;
   logic                 ctrl_rdone_o;
   axim_pkg::axi_data_t  rd_tdata_o;
   logic                 rd_tvalid_o;
   logic                 rd_tlast_o;
   logic                 rd_tready_i;
   logic                 ctrl_wstart_i;
   axim_pkg::axi_addr_t  ctrl_waddr_offset_i;
   axim_pkg::xfer_size_t ctrl_wxfer_size_i;
   logic                 ctrl_wstrb_msk_en_i;
   logic                 ctrl_wdone_o;
   axim_pkg::axi_data_t  wr_tdata_i;
   axim_pkg::axi_strb_t  wr_tstrb_msk_i;
   logic                 wr_tvalid_i;
   logic                 wr_tready_o;

   axim_pkg::axi_ax_t aw;
   axim_pkg::axi_ax_t ar;
   axim_pkg::axi_w_t  w;
   axim_pkg::axi_r_t  r;
   logic awvalid;
   logic awready;
   logic wvalid;
   logic wready;
   logic bvalid;
   logic bready;
   logic arvalid;
   logic arready;
   logic rvalid;
   logic rready;

   logic [31:0]         pat_mem [0:NUM_TESTS*PAT_FIELDS-1];
   // Shadow of what memory should hold
   axim_pkg::axi_data_t exp_mem [0:MEM_WORDS-1];

   int unsigned err_cnt   = 0;
   int unsigned check_cnt = 0;
   int unsigned rdone_cnt = 0;
   int unsigned wdone_cnt = 0;
   time         rdone_time;
   time         wdone_time;

   v_mem_subsystem dut_i (
      .clk (clk), .arst_n_i (arst_n_i), .ctrl_baseaddr_i (ctrl_baseaddr_i),
      .ctrl_rstart_i (ctrl_rstart_i), .ctrl_raddr_offset_i (ctrl_raddr_offset_i),
      .ctrl_rxfer_size_i (ctrl_rxfer_size_i), .ctrl_rdone_o (ctrl_rdone_o),
      .rd_tdata_o (rd_tdata_o), .rd_tvalid_o (rd_tvalid_o), .rd_tlast_o (rd_tlast_o),
      .rd_tready_i (rd_tready_i), .ctrl_wstart_i (ctrl_wstart_i),
      .ctrl_waddr_offset_i (ctrl_waddr_offset_i), .ctrl_wxfer_size_i (ctrl_wxfer_size_i),
      .ctrl_wstrb_msk_en_i (ctrl_wstrb_msk_en_i), .ctrl_wdone_o (ctrl_wdone_o),
      .wr_tdata_i (wr_tdata_i), .wr_tstrb_msk_i (wr_tstrb_msk_i),
      .wr_tvalid_i (wr_tvalid_i), .wr_tready_o (wr_tready_o),
      .aw_o (aw), .awvalid_o (awvalid), .awready_i (awready),
      .w_o (w), .wvalid_o (wvalid), .wready_i (wready),
      .bvalid_i (bvalid), .bready_o (bready),
      .ar_o (ar), .arvalid_o (arvalid), .arready_i (arready),
      .r_i (r), .rvalid_i (rvalid), .rready_o (rready)
   );

   axim_mem_model #(.MEM_WORDS (MEM_WORDS)) mem_i (
      .clk (clk), .arst_n_i (arst_n_i),
      .aw_i (aw), .awvalid_i (awvalid), .awready_o (awready),
      .w_i (w), .wvalid_i (wvalid), .wready_o (wready),
      .bvalid_o (bvalid), .bready_i (bready),
      .ar_i (ar), .arvalid_i (arvalid), .arready_o (arready),
      .r_o (r), .rvalid_o (rvalid), .rready_i (rready)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      if (ctrl_rdone_o) begin
         rdone_cnt  <= rdone_cnt + 1;
         rdone_time <= $time;
      end
      if (ctrl_wdone_o) begin
         wdone_cnt  <= wdone_cnt + 1;
         wdone_time <= $time;
      end
   end

   function automatic axim_pkg::axi_data_t initial_word(input int unsigned idx);
      return axim_pkg::axi_data_t'(idx * BEAT_BYTES) ^ FILL_KEY;
   endfunction

   function automatic logic random_bit();
      return ($urandom % 4) != 0;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
      check_cnt++;
      if (exp_val !== act_val) begin
         err_cnt++;
         $display("Fail at %0d ns: %s expected %h actual %h", $time, name, exp_val, act_val);
      end
   endtask

   // No valid, ready, done or last may be up while nothing is requested
   task automatic check_reset_outputs();
      check_value("ctrl_rdone_o", 32'd0, 32'(ctrl_rdone_o));
      check_value("ctrl_wdone_o", 32'd0, 32'(ctrl_wdone_o));
      check_value("rd_tvalid_o", 32'd0, 32'(rd_tvalid_o));
      check_value("rd_tlast_o", 32'd0, 32'(rd_tlast_o));
      check_value("wr_tready_o", 32'd0, 32'(wr_tready_o));
      check_value("awvalid_o", 32'd0, 32'(awvalid));
      check_value("wvalid_o", 32'd0, 32'(wvalid));
      check_value("bready_o", 32'd0, 32'(bready));
      check_value("arvalid_o", 32'd0, 32'(arvalid));
      check_value("rready_o", 32'd0, 32'(rready));
   endtask

   task automatic merge_expected(input int unsigned idx, input axim_pkg::axi_data_t data,
                                 input axim_pkg::axi_strb_t strb);
      for (int b = 0; b < BEAT_BYTES; b++) begin
         if (strb[b]) begin
            exp_mem[idx][8*b +: 8] = data[8*b +: 8];
         end
      end
   endtask

   // Burst k starts 64 bytes after burst k-1 and carries up to 16 beats
   task automatic check_bursts(input string chan, input axim_pkg::axi_ax_t log_q [$],
                               input axim_pkg::axi_addr_t addr, input int unsigned words,
                               input int unsigned bursts);
      int unsigned left;
      int unsigned beats;
      left = words;
      check_value({chan, " burst count"}, bursts, log_q.size());
      foreach (log_q[k]) begin
         beats = (left > `AXIM_MAX_BURST) ? `AXIM_MAX_BURST : left;
         check_value($sformatf("%saddr[%0d]", chan, k), addr + k * BURST_BYTES, log_q[k].addr);
         check_value($sformatf("%slen[%0d]", chan, k), beats - 1, log_q[k].len);
         left = left - beats;
      end
   endtask

   task automatic consume_read(input int unsigned first_idx, input int unsigned words,
                               input int unsigned done_goal);
      int unsigned beat;
      beat = 0;
      while (rdone_cnt < done_goal) begin
         rd_tready_i = random_bit();
         @(posedge clk);
         if (rd_tvalid_o && rd_tready_i) begin
            check_value("rd_tdata_o", exp_mem[(first_idx + beat) % MEM_WORDS], rd_tdata_o);
            check_value("rd_tlast_o", 32'(beat == words - 1), 32'(rd_tlast_o));
            beat++;
         end
         #1;
      end
      rd_tready_i = 1'b0;
      check_value("read beat count", words, beat);
   endtask

   task automatic produce_write(input int unsigned t, input int unsigned first_idx,
                                input int unsigned words, input logic msk_en,
                                input axim_pkg::axi_strb_t mask, input int unsigned done_goal);
      int unsigned beat;
      logic        fired;
      beat  = 0;
      fired = 1'b1;
      while (beat < words) begin
         // Once raised, valid holds until the beat is taken
         if (fired || !wr_tvalid_i) begin
            wr_tvalid_i = random_bit();
         end
         wr_tdata_i     = axim_pkg::axi_data_t'(beat + t);
         wr_tstrb_msk_i = msk_en ? mask : axim_pkg::axi_strb_t'(~beat);
         @(posedge clk);
         fired = wr_tvalid_i && wr_tready_o;
         if (fired) begin
            merge_expected(first_idx + beat, wr_tdata_i, msk_en ? wr_tstrb_msk_i : '1);
            beat++;
         end
         #1;
      end
      wr_tvalid_i = 1'b0;
      while (wdone_cnt < done_goal) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic run_test(input int unsigned t);
      logic [31:0]         dir;
      logic [31:0]         off;
      logic [31:0]         size;
      logic [31:0]         msk_en;
      logic [31:0]         mask;
      logic [31:0]         bursts;
      axim_pkg::axi_addr_t addr;
      int unsigned         words;
      int unsigned         first_idx;
      int unsigned         err_before;
      int unsigned         rgoal;
      int unsigned         wgoal;
      dir        = pat_mem[t*PAT_FIELDS];
      off        = pat_mem[t*PAT_FIELDS+1];
      size       = pat_mem[t*PAT_FIELDS+2];
      msk_en     = pat_mem[t*PAT_FIELDS+3];
      mask       = pat_mem[t*PAT_FIELDS+4];
      bursts     = pat_mem[t*PAT_FIELDS+5];
      addr       = BASE_ADDR + off;
      words      = size / BEAT_BYTES;
      first_idx  = (addr / BEAT_BYTES) % MEM_WORDS;
      err_before = err_cnt;
      rgoal      = rdone_cnt + 32'(dir != 1);
      wgoal      = wdone_cnt + 32'(dir != 0);
      mem_i.ar_log_q.delete();
      mem_i.aw_log_q.delete();

      // Direction 2 starts both requests in the same cycle
      ctrl_raddr_offset_i = off;
      ctrl_rxfer_size_i   = size;
      ctrl_waddr_offset_i = off;
      ctrl_wxfer_size_i   = size;
      ctrl_wstrb_msk_en_i = msk_en[0];
      ctrl_rstart_i       = (dir != 1);
      ctrl_wstart_i       = (dir != 0);
      @(posedge clk);
      #1;
      ctrl_rstart_i = 1'b0;
      ctrl_wstart_i = 1'b0;
      fork
         if (dir != 1) consume_read(first_idx, words, rgoal);
         if (dir != 0) produce_write(t, first_idx, words, msk_en[0], mask[3:0], wgoal);
      join
      repeat (4) @(posedge clk);
      #1;

      check_value("ctrl_rdone_o pulses", rgoal, rdone_cnt);
      check_value("ctrl_wdone_o pulses", wgoal, wdone_cnt);
      if (dir != 1) begin
         check_bursts("ar", mem_i.ar_log_q, addr, words, bursts);
      end
      if (dir != 0) begin
         check_bursts("aw", mem_i.aw_log_q, addr, words, bursts);
         // One word on each side must stay untouched
         for (int i = first_idx - 1; i <= first_idx + words; i++) begin
            check_value($sformatf("mem[%0d]", i), exp_mem[i], mem_i.mem[i]);
         end
      end
      if (dir == 2) begin
         check_value("read done before write done", 1, 32'(rdone_time < wdone_time));
      end
      $display("Test %0d dir %0d offset %h size %0d bursts %0d: %s", t, dir, off, size,
               bursts, (err_cnt == err_before) ? "ok" : "FAILED");
   endtask

   task automatic watchdog(input int unsigned cycles);
      repeat (cycles) @(posedge clk);
      $display("Run timed out after %0d cycles without finishing the tests", cycles);
      $display("Test failures found");
      $finish;
   endtask

   initial begin
      int unsigned limit;
      void'($urandom(32'h7ee));
      clk                 = 1'b0;
      arst_n_i            = 1'b0;
      ctrl_baseaddr_i     = BASE_ADDR;
      ctrl_rstart_i       = 1'b0;
      ctrl_raddr_offset_i = '0;
      ctrl_rxfer_size_i   = '0;
      ctrl_wstart_i       = 1'b0;
      ctrl_waddr_offset_i = '0;
      ctrl_wxfer_size_i   = '0;
      ctrl_wstrb_msk_en_i = 1'b0;
      rd_tready_i         = 1'b0;
      wr_tdata_i          = '0;
      wr_tstrb_msk_i      = '0;
      wr_tvalid_i         = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         exp_mem[i] = initial_word(i);
      end
      $readmemh("verification/axim_patterns.txt", pat_mem);

      // 40 cycles per byte moved, plus setup
      limit = 1000;
      for (int t = 0; t < NUM_TESTS; t++) begin
         limit += pat_mem[t*PAT_FIELDS+2] * 40 * ((pat_mem[t*PAT_FIELDS] == 2) ? 2 : 1);
      end
      fork
         watchdog(limit);
      join_none

      repeat (16) @(posedge clk);
      #1;
      arst_n_i = 1'b1;
      @(posedge clk);
      #1;
      check_reset_outputs();
      for (int t = 0; t < NUM_TESTS; t++) begin
         run_test(t);
      end

      $display("Tests run %0d, checks %0d, errors %0d", NUM_TESTS, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* verification/axim_patterns.txt */
// dir (0 read, 1 write, 2 read and write together) offset size mask_en mask bursts
// Offset and size in bytes from the base address, all values hex
0 000 010 0 0 1
0 044 040 0 0 1
0 100 0c4 0 0 4
1 200 020 0 0 1
1 240 0a0 0 0 3
1 300 050 1 5 2
1 380 010 1 c 1
2 400 048 0 0 2
0 200 0a0 0 0 3
0 300 050 0 0 2

/* all.f */
+incdir+source
source/axim_pkg.sv
source/axim_ctrl_fsm.sv
source/axim_burst_addr.sv
source/axim_rd_path.sv
source/axim_wr_path.sv
source/v_mem_subsystem.sv
verification/axim_mem_model.sv
verification/tb_v_mem_subsystem.sv

/* Makefile */
# Verilator build and run for the vector memory subsystem

VERILATOR ?= verilator
TOP       ?= tb_v_mem_subsystem
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= Test failures found

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, a crash also counts as failure
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
